//--- design/pi1_bus_pkg.sv
//####################################################################
// Bus widths and operation codes shared by every PI1 bus-facing file.
//####################################################################

package pi1_bus_pkg;

	// Data word width in bits.
	localparam int ARCHBITSZ = 32;

	// One select bit per byte lane.
	localparam int SELBITSZ = ARCHBITSZ / 8;

	// Word address, the byte offset bits are not carried on the bus.
	localparam int ADDRBITSZ = ARCHBITSZ - $clog2(SELBITSZ);

	localparam logic [1:0] PINOOP = 2'b00;
	localparam logic [1:0] PIWROP = 2'b01;
	localparam logic [1:0] PIRDOP = 2'b10;
	localparam logic [1:0] PIRWOP = 2'b11; // Atomic swap, old word is returned.

endpackage

//--- design/pi1_map_pkg.sv
//####################################################################
// Interconnect size and address map description for the subsystem.
//####################################################################

package pi1_map_pkg;

	localparam int MASTERCOUNT = 2;
	localparam int SLAVECOUNT  = 2;

	// Word address where the first slave starts.
	localparam int FIRSTSLAVEADDR = 0;

	// Depths in words, the decoder learns them from the slaves at run time.
	localparam int SLAVE0_DEPTH = 16;
	localparam int SLAVE1_DEPTH = 8;

	localparam int SLAVEIDXBITSZ = 1;

endpackage

//--- design/pi1_master_arbiter.sv
//####################################################################
// Round-robin arbiter between the two master ports of the interconnect.
// Forwards the granted request and returns ready to that master only.
//####################################################################

module pi1_master_arbiter
	import pi1_bus_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic [1:0]           m0_op_i,
	input  logic [ADDRBITSZ-1:0] m0_addr_i,
	input  logic [ARCHBITSZ-1:0] m0_data_i,
	input  logic [SELBITSZ-1:0]  m0_sel_i,
	input  logic [1:0]           m1_op_i,
	input  logic [ADDRBITSZ-1:0] m1_addr_i,
	input  logic [ARCHBITSZ-1:0] m1_data_i,
	input  logic [SELBITSZ-1:0]  m1_sel_i,
	input  logic                 accept_i,
	output logic [1:0]           req_op_o,
	output logic [ADDRBITSZ-1:0] req_addr_o,
	output logic [ARCHBITSZ-1:0] req_data_o,
	output logic [SELBITSZ-1:0]  req_sel_o,
	output logic                 req_master_o,
	output logic                 m0_rdy_o,
	output logic                 m1_rdy_o
);

	logic grant_q;

	always_comb begin
		if (grant_q) begin
			req_op_o   = m1_op_i;
			req_addr_o = m1_addr_i;
			req_data_o = m1_data_i;
			req_sel_o  = m1_sel_i;
		end else begin
			req_op_o   = m0_op_i;
			req_addr_o = m0_addr_i;
			req_data_o = m0_data_i;
			req_sel_o  = m0_sel_i;
		end
	end

	assign req_master_o = grant_q;
	assign m0_rdy_o     = accept_i && !grant_q;
	assign m1_rdy_o     = accept_i && grant_q;

	// An idle granted master gives up its turn, so a lone requester waits at most a cycle.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			grant_q <= 1'b0;
		end else if (accept_i || req_op_o == PINOOP) begin
			grant_q <= ~grant_q;
		end
	end

endmodule

//--- design/pi1_addr_decoder.sv
//####################################################################
// Learns the slave address map after reset from the slaves' map sizes,
// then resolves each request address into a slave index and offset.
//####################################################################

module pi1_addr_decoder
	import pi1_bus_pkg::*, pi1_map_pkg::*;
(
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic [1:0]               req_op_i,
	input  logic [ADDRBITSZ-1:0]     req_addr_i,
	input  logic [ADDRBITSZ-1:0]     s0_mapsz_i,
	input  logic [ADDRBITSZ-1:0]     s1_mapsz_i,
	output logic                     map_ready_o,
	output logic                     hit_o,
	output logic [SLAVEIDXBITSZ-1:0] slave_idx_o,
	output logic [ADDRBITSZ-1:0]     slave_offset_o
);

	logic [ADDRBITSZ-1:0]     mapsz [SLAVECOUNT];
	logic [ADDRBITSZ-1:0]     lo_q [SLAVECOUNT];
	logic [ADDRBITSZ-1:0]     hi_q [SLAVECOUNT];
	logic [SLAVEIDXBITSZ:0]   scan_q; // Counts to SLAVECOUNT, one bit wider than an index.
	logic [SLAVEIDXBITSZ-1:0] scan_idx;
	logic [ADDRBITSZ-1:0]     base_q;
	logic                     map_ready_q;
	logic                     scan_store;

	assign mapsz[0] = s0_mapsz_i;
	assign mapsz[1] = s1_mapsz_i;

	assign scan_idx    = scan_q[SLAVEIDXBITSZ-1:0];
	assign scan_store  = !rst_i && !map_ready_q && scan_q != SLAVECOUNT;
	assign map_ready_o = map_ready_q;

	// One slave per cycle, then a final cycle to raise ready.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			scan_q      <= '0;
			base_q      <= ADDRBITSZ'(FIRSTSLAVEADDR);
			map_ready_q <= 1'b0;
		end else if (!map_ready_q) begin
			if (scan_q == SLAVECOUNT) begin
				map_ready_q <= 1'b1;
			end else begin
				base_q <= base_q + mapsz[scan_idx];
				scan_q <= scan_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (scan_store) begin
			lo_q[scan_idx] <= base_q;
			hi_q[scan_idx] <= base_q + mapsz[scan_idx] - 1'b1; // Last word of the slave.
		end
	end

	// Lowest matching slave wins if ranges ever overlap.
	always_comb begin
		hit_o          = 1'b0;
		slave_idx_o    = '0;
		slave_offset_o = '0;
		for (int i = SLAVECOUNT - 1; i >= 0; i--) begin
			if (map_ready_q && req_op_i != PINOOP &&
			    req_addr_i >= lo_q[i] && req_addr_i <= hi_q[i]) begin
				hit_o          = 1'b1;
				slave_idx_o    = SLAVEIDXBITSZ'(i);
				slave_offset_o = req_addr_i - lo_q[i];
			end
		end
	end

endmodule

//--- design/pi1_slave_port.sv
//####################################################################
// Drives the selected slave, answers unmapped requests as a null slave
// and returns read words to the requesting master.
//####################################################################

module pi1_slave_port
	import pi1_bus_pkg::*, pi1_map_pkg::*;
(
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  logic                           map_ready_i,
	input  logic                           hit_i,
	input  logic [SLAVEIDXBITSZ-1:0]       slave_idx_i,
	input  logic [ADDRBITSZ-1:0]           slave_offset_i,
	input  logic [1:0]                     req_op_i,
	input  logic [ARCHBITSZ-1:0]           req_data_i,
	input  logic [SELBITSZ-1:0]            req_sel_i,
	input  logic [$clog2(MASTERCOUNT)-1:0] req_master_i,
	input  logic [ARCHBITSZ-1:0]           s0_rdq_i,
	input  logic                           s0_rdy_i,
	input  logic [ARCHBITSZ-1:0]           s1_rdq_i,
	input  logic                           s1_rdy_i,
	output logic                           accept_o,
	output logic [1:0]                     s0_op_o,
	output logic [ADDRBITSZ-1:0]           s0_addr_o,
	output logic [ARCHBITSZ-1:0]           s0_data_o,
	output logic [SELBITSZ-1:0]            s0_sel_o,
	output logic [1:0]                     s1_op_o,
	output logic [ADDRBITSZ-1:0]           s1_addr_o,
	output logic [ARCHBITSZ-1:0]           s1_data_o,
	output logic [SELBITSZ-1:0]            s1_sel_o,
	output logic [ARCHBITSZ-1:0]           m0_data_o,
	output logic [ARCHBITSZ-1:0]           m1_data_o
);

	logic [ARCHBITSZ-1:0]           rdq [SLAVECOUNT];
	logic                           s_rdy [SLAVECOUNT];
	logic                           target_rdy;
	logic                           rd_take;
	logic                           rd_pend_q;
	logic                           rd_null_q;
	logic [SLAVEIDXBITSZ-1:0]       rd_idx_q;
	logic [$clog2(MASTERCOUNT)-1:0] rd_master_q;
	logic [ARCHBITSZ-1:0]           rd_word;
	logic [ARCHBITSZ-1:0]           m0_data_q;
	logic [ARCHBITSZ-1:0]           m1_data_q;

	assign rdq[0]   = s0_rdq_i;
	assign rdq[1]   = s1_rdq_i;
	assign s_rdy[0] = s0_rdy_i;
	assign s_rdy[1] = s1_rdy_i;

	assign target_rdy = hit_i ? s_rdy[slave_idx_i] : 1'b1; // The null slave never stalls.
	assign accept_o   = map_ready_i && target_rdy;
	assign rd_take    = accept_o && (req_op_i == PIRDOP || req_op_i == PIRWOP);

	assign s0_op_o   = (accept_o && hit_i && slave_idx_i == 1'b0) ? req_op_i : PINOOP;
	assign s1_op_o   = (accept_o && hit_i && slave_idx_i == 1'b1) ? req_op_i : PINOOP;
	assign s0_addr_o = slave_offset_i;
	assign s1_addr_o = slave_offset_i;
	assign s0_data_o = req_data_i;
	assign s1_data_o = req_data_i;
	assign s0_sel_o  = req_sel_i;
	assign s1_sel_o  = req_sel_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_pend_q <= 1'b0;
		end else begin
			rd_pend_q <= rd_take;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rd_take) begin
			rd_null_q   <= !hit_i;
			rd_idx_q    <= slave_idx_i;
			rd_master_q <= req_master_i;
		end
	end

	assign rd_word = rd_null_q ? '1 : rdq[rd_idx_q];

	// Word is live in the cycle after acceptance, then held until the next read.
	always_ff @(posedge clk_i) begin
		if (rd_pend_q) begin
			if (rd_master_q == 1'b0) begin
				m0_data_q <= rd_word;
			end else begin
				m1_data_q <= rd_word;
			end
		end
	end

	assign m0_data_o = (rd_pend_q && rd_master_q == 1'b0) ? rd_word : m0_data_q;
	assign m1_data_o = (rd_pend_q && rd_master_q == 1'b1) ? rd_word : m1_data_q;

endmodule

//--- design/pi1_ram_slave.sv
//####################################################################
// Word RAM slave with byte selects, swap and a registered read port.
//####################################################################

module pi1_ram_slave
	import pi1_bus_pkg::*;
#(
	parameter int DEPTH = 16
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic [1:0]           op_i,
	input  logic [ADDRBITSZ-1:0] addr_i,
	input  logic [ARCHBITSZ-1:0] data_i,
	input  logic [SELBITSZ-1:0]  sel_i,
	output logic [ARCHBITSZ-1:0] rdq_o,
	output logic                 rdy_o,
	output logic [ADDRBITSZ-1:0] mapsz_o
);

	logic [ARCHBITSZ-1:0]      mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]  word_idx;
	logic [ARCHBITSZ-1:0]      rdq_q;

	assign word_idx = addr_i[$clog2(DEPTH)-1:0]; // The decoder keeps offsets below DEPTH.

	always_ff @(posedge clk_i) begin
		if (op_i == PIWROP || op_i == PIRWOP) begin
			for (int b = 0; b < SELBITSZ; b++) begin
				if (sel_i[b]) begin
					mem[word_idx][b*8 +: 8] <= data_i[b*8 +: 8];
				end
			end
		end
	end

	// A swap reads the word as it was before this edge's write.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdq_q <= '0;
		end else if (op_i == PIRDOP || op_i == PIRWOP) begin
			rdq_q <= mem[word_idx];
		end
	end

	assign rdq_o   = rdq_q;
	assign rdy_o   = 1'b1;
	assign mapsz_o = ADDRBITSZ'(DEPTH);

endmodule

//--- design/pi1_subsystem_top.sv
//####################################################################
// Two-master PI1 interconnect with two RAM slaves behind it.
//####################################################################

module pi1_subsystem_top
	import pi1_bus_pkg::*, pi1_map_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic [1:0]           m0_op_i,
	input  logic [ADDRBITSZ-1:0] m0_addr_i,
	input  logic [ARCHBITSZ-1:0] m0_data_i,
	input  logic [SELBITSZ-1:0]  m0_sel_i,
	output logic                 m0_rdy_o,
	output logic [ARCHBITSZ-1:0] m0_data_o,
	input  logic [1:0]           m1_op_i,
	input  logic [ADDRBITSZ-1:0] m1_addr_i,
	input  logic [ARCHBITSZ-1:0] m1_data_i,
	input  logic [SELBITSZ-1:0]  m1_sel_i,
	output logic                 m1_rdy_o,
	output logic [ARCHBITSZ-1:0] m1_data_o
);

	logic [1:0]                     req_op;
	logic [ADDRBITSZ-1:0]           req_addr;
	logic [ARCHBITSZ-1:0]           req_data;
	logic [SELBITSZ-1:0]            req_sel;
	logic [$clog2(MASTERCOUNT)-1:0] req_master;
	logic                           accept;
	logic                           map_ready;
	logic                           hit;
	logic [SLAVEIDXBITSZ-1:0]       slave_idx;
	logic [ADDRBITSZ-1:0]           slave_offset;
	logic [1:0]                     s0_op;
	logic [ADDRBITSZ-1:0]           s0_addr;
	logic [ARCHBITSZ-1:0]           s0_data;
	logic [SELBITSZ-1:0]            s0_sel;
	logic [ARCHBITSZ-1:0]           s0_rdq;
	logic                           s0_rdy;
	logic [ADDRBITSZ-1:0]           s0_mapsz;
	logic [1:0]                     s1_op;
	logic [ADDRBITSZ-1:0]           s1_addr;
	logic [ARCHBITSZ-1:0]           s1_data;
	logic [SELBITSZ-1:0]            s1_sel;
	logic [ARCHBITSZ-1:0]           s1_rdq;
	logic                           s1_rdy;
	logic [ADDRBITSZ-1:0]           s1_mapsz;

	pi1_master_arbiter pi1_master_arbiter_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.m0_op_i(m0_op_i), .m0_addr_i(m0_addr_i), .m0_data_i(m0_data_i), .m0_sel_i(m0_sel_i),
		.m1_op_i(m1_op_i), .m1_addr_i(m1_addr_i), .m1_data_i(m1_data_i), .m1_sel_i(m1_sel_i),
		.accept_i(accept),
		.req_op_o(req_op), .req_addr_o(req_addr), .req_data_o(req_data), .req_sel_o(req_sel),
		.req_master_o(req_master), .m0_rdy_o(m0_rdy_o), .m1_rdy_o(m1_rdy_o)
	);

	pi1_addr_decoder pi1_addr_decoder_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.req_op_i(req_op), .req_addr_i(req_addr),
		.s0_mapsz_i(s0_mapsz), .s1_mapsz_i(s1_mapsz),
		.map_ready_o(map_ready), .hit_o(hit),
		.slave_idx_o(slave_idx), .slave_offset_o(slave_offset)
	);

	pi1_slave_port pi1_slave_port_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.map_ready_i(map_ready), .hit_i(hit), .slave_idx_i(slave_idx),
		.slave_offset_i(slave_offset), .req_op_i(req_op), .req_data_i(req_data),
		.req_sel_i(req_sel), .req_master_i(req_master),
		.s0_rdq_i(s0_rdq), .s0_rdy_i(s0_rdy), .s1_rdq_i(s1_rdq), .s1_rdy_i(s1_rdy),
		.accept_o(accept),
		.s0_op_o(s0_op), .s0_addr_o(s0_addr), .s0_data_o(s0_data), .s0_sel_o(s0_sel),
		.s1_op_o(s1_op), .s1_addr_o(s1_addr), .s1_data_o(s1_data), .s1_sel_o(s1_sel),
		.m0_data_o(m0_data_o), .m1_data_o(m1_data_o)
	);

	pi1_ram_slave #(.DEPTH(SLAVE0_DEPTH)) pi1_ram_slave0_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.op_i(s0_op), .addr_i(s0_addr), .data_i(s0_data), .sel_i(s0_sel),
		.rdq_o(s0_rdq), .rdy_o(s0_rdy), .mapsz_o(s0_mapsz)
	);

	pi1_ram_slave #(.DEPTH(SLAVE1_DEPTH)) pi1_ram_slave1_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.op_i(s1_op), .addr_i(s1_addr), .data_i(s1_data), .sel_i(s1_sel),
		.rdq_o(s1_rdq), .rdy_o(s1_rdy), .mapsz_o(s1_mapsz)
	);

endmodule

//--- testbench/pi1_assertions.sv
//####################################################################
// Protocol checks on the master arbiter, bound into every arbiter.
//####################################################################

module pi1_assertions
	import pi1_bus_pkg::*, pi1_map_pkg::*;
(
	input logic                 clk_i,
	input logic                 rst_i,
	input logic [1:0]           m0_op_i,
	input logic [ADDRBITSZ-1:0] m0_addr_i,
	input logic [ARCHBITSZ-1:0] m0_data_i,
	input logic [SELBITSZ-1:0]  m0_sel_i,
	input logic                 m0_rdy_i,
	input logic [1:0]           m1_op_i,
	input logic [ADDRBITSZ-1:0] m1_addr_i,
	input logic [ARCHBITSZ-1:0] m1_data_i,
	input logic [SELBITSZ-1:0]  m1_sel_i,
	input logic                 m1_rdy_i
);

	int warm_q; // Cycles since reset release. It saturates once the map scan is over.
	int fail_count = 0;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			warm_q <= 0;
		end else if (warm_q < SLAVECOUNT + 1) begin
			warm_q <= warm_q + 1;
		end
	end

	one_ready: assert property (@(posedge clk_i) !(m0_rdy_i && m1_rdy_i))
		else begin
			$error("Both masters were ready in the same cycle.");
			fail_count++;
		end

	no_early_ready: assert property (@(posedge clk_i)
		(rst_i || warm_q < SLAVECOUNT + 1) |-> !(m0_rdy_i || m1_rdy_i))
		else begin
			$error("A master was ready during reset or before the map was learned.");
			fail_count++;
		end

	m0_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		(m0_op_i != PINOOP && !m0_rdy_i) |=> $stable({m0_op_i, m0_addr_i, m0_data_i, m0_sel_i}))
		else begin
			$error("Master 0 changed a request before it was accepted.");
			fail_count++;
		end

	m1_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		(m1_op_i != PINOOP && !m1_rdy_i) |=> $stable({m1_op_i, m1_addr_i, m1_data_i, m1_sel_i}))
		else begin
			$error("Master 1 changed a request before it was accepted.");
			fail_count++;
		end

endmodule

bind pi1_master_arbiter pi1_assertions pi1_assertions_inst (
	.clk_i(clk_i), .rst_i(rst_i),
	.m0_op_i(m0_op_i), .m0_addr_i(m0_addr_i), .m0_data_i(m0_data_i), .m0_sel_i(m0_sel_i),
	.m0_rdy_i(m0_rdy_o),
	.m1_op_i(m1_op_i), .m1_addr_i(m1_addr_i), .m1_data_i(m1_data_i), .m1_sel_i(m1_sel_i),
	.m1_rdy_i(m1_rdy_o)
);

//--- testbench/pi1_checker.sv
//####################################################################
// Compares each read result on the master ports with its expected word.
//####################################################################

module pi1_checker
	import pi1_bus_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 m0_rdy_i,
	input  logic [1:0]           m0_op_i,
	input  logic [ARCHBITSZ-1:0] m0_exp_i,
	input  logic [ARCHBITSZ-1:0] m0_data_i,
	input  logic                 m1_rdy_i,
	input  logic [1:0]           m1_op_i,
	input  logic [ARCHBITSZ-1:0] m1_exp_i,
	input  logic [ARCHBITSZ-1:0] m1_data_i,
	output int                   err_count_o,
	output int                   check_count_o
);

	logic                 pend_q [2];
	logic [ARCHBITSZ-1:0] exp_q [2];

	function automatic logic returns_word(input logic [1:0] op);
		return op == PIRDOP || op == PIRWOP;
	endfunction

	task automatic compare_word(input string name, input logic [ARCHBITSZ-1:0] exp, act);
		check_count_o++;
		if (act !== exp) begin
			err_count_o++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// The word is due in the cycle after acceptance, so it is compared at the edge closing it.
	always @(posedge clk_i) begin
		if (rst_i) begin
			pend_q[0] = 1'b0;
			pend_q[1] = 1'b0;
			err_count_o = 0;
			check_count_o = 0;
		end else begin
			if (pend_q[0]) compare_word("m0_data_o", exp_q[0], m0_data_i);
			if (pend_q[1]) compare_word("m1_data_o", exp_q[1], m1_data_i);
			pend_q[0] = m0_rdy_i && returns_word(m0_op_i);
			pend_q[1] = m1_rdy_i && returns_word(m1_op_i);
			exp_q[0] = m0_exp_i;
			exp_q[1] = m1_exp_i;
		end
	end

endmodule

//--- testbench/tb_pi1_subsystem.sv
//####################################################################
// Testbench for the PI1 subsystem. It runs both masters from the vector file.
//####################################################################

module tb_pi1_subsystem
	import pi1_bus_pkg::*;
();

	localparam int MAXVEC = 64;
	localparam int FIELDS = 6; // Master, op, address, data, select, expected word.

	logic                 clk_i;
	logic                 rst_i;
	logic [1:0]           m_op [2];
	logic [ADDRBITSZ-1:0] m_addr [2];
	logic [ARCHBITSZ-1:0] m_data [2];
	logic [SELBITSZ-1:0]  m_sel [2];
	logic [ARCHBITSZ-1:0] m_exp [2];
	logic                 m_rdy [2];
	logic [ARCHBITSZ-1:0] m_rdata [2];
	logic [31:0]          vec_mem [MAXVEC*FIELDS];
	int                   q0 [$];
	int                   q1 [$];
	int                   err_count;
	int                   check_count;

	pi1_subsystem_top pi1_subsystem_top_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.m0_op_i(m_op[0]), .m0_addr_i(m_addr[0]), .m0_data_i(m_data[0]), .m0_sel_i(m_sel[0]),
		.m0_rdy_o(m_rdy[0]), .m0_data_o(m_rdata[0]),
		.m1_op_i(m_op[1]), .m1_addr_i(m_addr[1]), .m1_data_i(m_data[1]), .m1_sel_i(m_sel[1]),
		.m1_rdy_o(m_rdy[1]), .m1_data_o(m_rdata[1])
	);

	pi1_checker pi1_checker_inst (
		.clk_i(clk_i), .rst_i(rst_i),
		.m0_rdy_i(m_rdy[0]), .m0_op_i(m_op[0]), .m0_exp_i(m_exp[0]), .m0_data_i(m_rdata[0]),
		.m1_rdy_i(m_rdy[1]), .m1_op_i(m_op[1]), .m1_exp_i(m_exp[1]), .m1_data_i(m_rdata[1]),
		.err_count_o(err_count), .check_count_o(check_count)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	task automatic drive_master(input int m);
		int n;
		int v;
		n = (m == 0) ? q0.size() : q1.size();
		@(posedge clk_i);
		for (int k = 0; k < n; k++) begin
			v = (m == 0) ? q0[k] : q1[k];
			#1;
			m_op[m]   = vec_mem[v*FIELDS+1][1:0];
			m_addr[m] = vec_mem[v*FIELDS+2][ADDRBITSZ-1:0];
			m_data[m] = vec_mem[v*FIELDS+3];
			m_sel[m]  = vec_mem[v*FIELDS+4][SELBITSZ-1:0];
			m_exp[m]  = vec_mem[v*FIELDS+5];
			do begin
				@(posedge clk_i);
			end while (!m_rdy[m]); // Held until this master is ready at an edge.
		end
		#1;
		m_op[m] = PINOOP;
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles) @(posedge clk_i);
		$display("Timeout: the requests did not all complete within %0d cycles", cycles);
		$display("Some tests failed");
		$finish;
	endtask

	initial begin
		int n_vec;
		int n_reads;
		int tb_errors;
		int assert_fails;
		rst_i = 1'b1;
		n_vec = 0;
		n_reads = 0;
		tb_errors = 0;
		assert_fails = 0;
		for (int m = 0; m < 2; m++) begin
			m_op[m] = PINOOP;
			m_addr[m] = '0;
			m_data[m] = '0;
			m_sel[m] = '0;
			m_exp[m] = '0;
		end
		$readmemh("testbench/pi1_input_vectors.txt", vec_mem);
		while (n_vec < MAXVEC && !$isunknown(vec_mem[n_vec*FIELDS])) begin
			if (vec_mem[n_vec*FIELDS] == 0) begin
				q0.push_back(n_vec);
			end else begin
				q1.push_back(n_vec);
			end
			if (vec_mem[n_vec*FIELDS+1] == PIRDOP || vec_mem[n_vec*FIELDS+1] == PIRWOP) begin
				n_reads++;
			end
			n_vec++;
		end
		fork
			watchdog(n_vec * 20 + 100);
		join_none
		repeat (5) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		fork
			drive_master(0);
			drive_master(1);
		join
		repeat (2) @(posedge clk_i); // Lets the last read result reach the checker.
		if (n_vec == 0 || check_count != n_reads) begin
			$display("Only %0d of %0d read results were checked", check_count, n_reads);
			tb_errors++;
		end
		assert_fails = pi1_subsystem_top_inst.pi1_master_arbiter_inst.pi1_assertions_inst.fail_count;
		$display("Read checks: %0d, data errors: %0d, assertion failures: %0d, other errors: %0d",
			check_count, err_count, assert_fails, tb_errors);
		if (err_count == 0 && assert_fails == 0 && tb_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- testbench/pi1_input_vectors.txt
// master op address data select expected, all hex; op 1 write, 2 read, 3 swap
// The expected word only matters for reads and swaps.
0 1 00000000 a0a0a0a0 f 00000000
1 1 00000010 b1b1b1b1 f 00000000
0 1 0000000f a0f0a0f0 f 00000000
1 1 00000017 b7b7b7b7 f 00000000
0 2 00000000 00000000 0 a0a0a0a0
1 2 00000010 00000000 0 b1b1b1b1
0 2 0000000f 00000000 0 a0f0a0f0
1 2 00000017 00000000 0 b7b7b7b7
0 1 00000002 11223344 f 00000000
1 1 00000014 00001111 f 00000000
0 1 00000002 aabbccdd 5 00000000
1 3 00000014 00002222 f 00001111
0 2 00000002 00000000 0 11bb33dd
1 2 00000014 00000000 0 00002222
0 1 00000003 cafe0001 f 00000000
1 1 00000005 01020304 f 00000000
0 3 00000003 5a5a5a5a f cafe0001
1 1 00000005 ffeeddcc a 00000000
0 2 00000003 00000000 0 5a5a5a5a
1 2 00000005 00000000 0 ff02dd04
0 1 00000008 0f0f0f0f f 00000000
0 1 00000018 deadbeef f 00000000
0 2 00000018 00000000 0 ffffffff
0 2 00000008 00000000 0 0f0f0f0f
1 3 00000019 12345678 f ffffffff
1 2 00000019 00000000 0 ffffffff

//--- all.f
design/pi1_bus_pkg.sv
design/pi1_map_pkg.sv
design/pi1_master_arbiter.sv
design/pi1_addr_decoder.sv
design/pi1_slave_port.sv
design/pi1_ram_slave.sv
design/pi1_subsystem_top.sv
testbench/pi1_assertions.sv
testbench/pi1_checker.sv
testbench/tb_pi1_subsystem.sv
